// File: compile.f
verilog/alu_pkg.sv
verilog/alu_logic.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/hilo_ctrl.sv
verilog/alu.sv
tb/tb_alu.sv

// File: Bender.yml
package:
  name: mips_alu

sources:
  - verilog/alu_pkg.sv
  - verilog/alu_logic.sv
  - verilog/mul_unit.sv
  - verilog/div_unit.sv
  - verilog/hilo_ctrl.sv
  - verilog/alu.sv
  - target: test
    files:
      - tb/tb_alu.sv

// File: tb/tb_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu;

    typedef struct packed {
        logic [alu_pkg::OP_W-1:0] op;
        logic [31:0]              a;
        logic [31:0]              b;
        logic [4:0]               sa;
        logic                     kill;
        logic                     rnd;
        logic [31:0]              res;
        logic                     ovf;
    } row_t;

    logic              clk;
    logic              rst_i;
    logic              flush_i;
    logic              hilo_kill_i;
    alu_pkg::alu_req_t req_i;
    logic [31:0]       result_o;
    logic              overflow_o;
    logic              stall_o;

    row_t        rows[$];
    logic [63:0] ref_hilo;
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          row_idx;
    int          cycles;
    int          cycle_limit;

    alu dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .flush_i     (flush_i),
        .hilo_kill_i (hilo_kill_i),
        .result_o    (result_o),
        .overflow_o  (overflow_o),
        .stall_o     (stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        int k;
        w = '0;
        for (k = 0; k < 32; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    // {remainder, quotient}, sign rules applied to the magnitude result
    function automatic logic [63:0] div_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        if (mb == 32'd0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (sgn && (a[31] ^ b[31])) q = -q;
        if (sgn && a[31]) r = -r;
        return {r, q};
    endfunction

    // reference model, also tracks hi/lo across rows
    task automatic model_op(input row_t r, output logic [31:0] res, output logic ovf);
        logic [63:0] prod_s;
        logic [63:0] prod_u;
        logic [63:0] nxt;
        prod_s = {{32{r.a[31]}}, r.a} * {{32{r.b[31]}}, r.b};
        prod_u = {32'd0, r.a} * {32'd0, r.b};
        res = '0;
        ovf = 1'b0;
        nxt = ref_hilo;
        case (r.op)
            alu_pkg::OP_ADD: begin
                res = r.a + r.b;
                ovf = (r.a[31] == r.b[31]) && (res[31] != r.a[31]);
            end
            alu_pkg::OP_MULT:  nxt = prod_s;
            alu_pkg::OP_MULTU: nxt = prod_u;
            alu_pkg::OP_MUL:   res = prod_s[31:0];
            alu_pkg::OP_MADD:  nxt = ref_hilo + prod_s;
            alu_pkg::OP_MADDU: nxt = ref_hilo + prod_u;
            alu_pkg::OP_MSUB:  nxt = ref_hilo - prod_s;
            alu_pkg::OP_MSUBU: nxt = ref_hilo - prod_u;
            alu_pkg::OP_DIV:   nxt = div_model(r.a, r.b, 1'b1);
            alu_pkg::OP_DIVU:  nxt = div_model(r.a, r.b, 1'b0);
            alu_pkg::OP_MTHI:  nxt = {r.a, ref_hilo[31:0]};
            alu_pkg::OP_MTLO:  nxt = {ref_hilo[63:32], r.a};
            alu_pkg::OP_MFHI:  res = ref_hilo[63:32];
            alu_pkg::OP_MFLO:  res = ref_hilo[31:0];
            default: ;
        endcase
        if (!r.kill) ref_hilo = nxt;
    endtask

    task automatic add_row(input logic [5:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] sa, input logic kill, input logic rnd,
                           input logic [31:0] res, input logic ovf);
        row_t r;
        r.op   = op;
        r.a    = a;
        r.b    = b;
        r.sa   = sa;
        r.kill = kill;
        r.rnd  = rnd;
        r.res  = res;
        r.ovf  = ovf;
        rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h (row %0d)", name, act, exp, row_idx);
        end
    endtask

    task automatic fill_table();
        // hi/lo cleared by reset
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_AND,   32'hf0f0_ff00, 32'h0ff0_0ff0, 0,  0, 0, 32'h00f0_0f00, 0);
        add_row(alu_pkg::OP_OR,    32'h1200_0034, 32'h0056_7800, 0,  0, 0, 32'h1256_7834, 0);
        add_row(alu_pkg::OP_NOR,   32'h0f0f_0000, 32'h0000_00f0, 0,  0, 0, 32'hf0f0_ff0f, 0);
        add_row(alu_pkg::OP_XOR,   32'haaaa_5555, 32'hffff_0000, 0,  0, 0, 32'h5555_5555, 0);
        add_row(alu_pkg::OP_SLT,   32'hffff_fffe, 32'h0000_0001, 0,  0, 0, 32'h1, 0);
        add_row(alu_pkg::OP_SLTU,  32'hffff_fffe, 32'h0000_0001, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_SLLV,  32'h0000_0004, 32'h0000_00f1, 0,  0, 0, 32'h0000_0f10, 0);
        add_row(alu_pkg::OP_SRLV,  32'h0000_0024, 32'h8000_0000, 0,  0, 0, 32'h0800_0000, 0);
        add_row(alu_pkg::OP_SRAV,  32'h0000_0008, 32'h8000_1200, 0,  0, 0, 32'hff80_0012, 0);
        add_row(alu_pkg::OP_SLL,   32'h0,         32'h0000_0003, 31, 0, 0, 32'h8000_0000, 0);
        add_row(alu_pkg::OP_SRL,   32'h0,         32'habcd_1234, 16, 0, 0, 32'h0000_abcd, 0);
        add_row(alu_pkg::OP_SRA,   32'h0,         32'hf000_0000, 4,  0, 0, 32'hff00_0000, 0);
        add_row(alu_pkg::OP_LUI,   32'h0,         32'h0000_beef, 0,  0, 0, 32'hbeef_0000, 0);
        add_row(alu_pkg::OP_SEB,   32'h0,         32'h0000_1280, 0,  0, 0, 32'hffff_ff80, 0);
        add_row(alu_pkg::OP_SEH,   32'h0,         32'h0001_7fff, 0,  0, 0, 32'h0000_7fff, 0);
        add_row(alu_pkg::OP_WSBH,  32'h0,         32'h1122_3344, 0,  0, 0, 32'h2211_4433, 0);
        add_row(alu_pkg::OP_NOP,   32'hdead_beef, 32'h0,         0,  0, 0, 32'hdead_beef, 0);
        // overflow only for the signed forms
        add_row(alu_pkg::OP_ADD,   32'h7fff_ffff, 32'h0000_0001, 0,  0, 0, 32'h8000_0000, 1);
        add_row(alu_pkg::OP_ADDU,  32'h7fff_ffff, 32'h0000_0001, 0,  0, 0, 32'h8000_0000, 0);
        add_row(alu_pkg::OP_SUB,   32'h8000_0000, 32'h0000_0001, 0,  0, 0, 32'h7fff_ffff, 1);
        add_row(alu_pkg::OP_SUBU,  32'h8000_0000, 32'h0000_0001, 0,  0, 0, 32'h7fff_ffff, 0);
        add_row(alu_pkg::OP_ADD,   32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        // multiply
        add_row(alu_pkg::OP_MULT,  32'hffff_fffd, 32'h0000_0007, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'hffff_ffff, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'hffff_ffeb, 0);
        add_row(alu_pkg::OP_MULTU, 32'hffff_fffd, 32'h0000_0007, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'h0000_0006, 0);
        add_row(alu_pkg::OP_MUL,   32'h0001_0000, 32'h0001_0003, 0,  0, 0, 32'h0003_0000, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'hffff_ffeb, 0);
        add_row(alu_pkg::OP_MULT,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        // divide, including a zero divisor
        add_row(alu_pkg::OP_DIV,   32'hffff_ffe9, 32'h0000_0005, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'hffff_fffc, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'hffff_fffd, 0);
        add_row(alu_pkg::OP_DIVU,  32'h0000_0064, 32'h0000_0007, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0000_000e, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'h0000_0002, 0);
        add_row(alu_pkg::OP_DIV,   32'hffff_fff6, 32'h0000_0000, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0000_0001, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'hffff_fff6, 0);
        add_row(alu_pkg::OP_DIV,   32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        // accumulate on a known hi/lo
        add_row(alu_pkg::OP_MTHI,  32'h0000_0001, 32'h0,         0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MTLO,  32'h0000_0010, 32'h0,         0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MADD,  32'h0000_0002, 32'hffff_fffd, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'h0000_0001, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0000_000a, 0);
        add_row(alu_pkg::OP_MSUBU, 32'hffff_ffff, 32'h0000_0002, 0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 0, 32'hffff_ffff, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0000_000c, 0);
        add_row(alu_pkg::OP_MADDU, 32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MSUB,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MFHI,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 1, 32'h0, 0);
        // killed writes leave hi/lo alone
        add_row(alu_pkg::OP_MTLO,  32'h0000_5555, 32'h0,         0,  0, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MTLO,  32'h1234_5678, 32'h0,         0,  1, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0000_5555, 0);
        add_row(alu_pkg::OP_MULT,  32'h0000_0002, 32'h0000_0003, 0,  1, 0, 32'h0, 0);
        add_row(alu_pkg::OP_MFLO,  32'h0,         32'h0,         0,  0, 0, 32'h0000_5555, 0);
    endtask

    // ends a run whose stall never drops
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles (row %0d)",
                     cycle_limit, row_idx);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        row_t        cur;
        logic [31:0] exp_res;
        logic        exp_ovf;
        int          stall_cnt;
        int          exp_stall;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        hilo_kill_i = 1'b0;
        req_i       = '0;
        ref_hilo    = '0;
        lfsr_q      = 32'hd4c41eac;
        errors      = 0;
        checks      = 0;
        row_idx     = 0;
        cycles      = 0;
        fill_table();
        cycle_limit = rows.size() * 40 + 100;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            cur = rows[row_idx];
            if (cur.rnd) begin
                draw_word(cur.a);
                draw_word(cur.b);
            end
            req_i.op    <= cur.op;
            req_i.src_a <= cur.a;
            req_i.src_b <= cur.b;
            req_i.sa    <= cur.sa;
            hilo_kill_i <= cur.kill;
            model_op(cur, exp_res, exp_ovf);
            if (!cur.rnd) begin
                exp_res = cur.res;
                exp_ovf = cur.ovf;
            end
            // mul/div class: one load cycle plus 32 steps
            exp_stall = (cur.op >= alu_pkg::OP_MULT && cur.op <= alu_pkg::OP_MSUBU) ? 33 : 0;
            stall_cnt = 0;
            @(negedge clk);
            while (stall_o) begin
                stall_cnt++;
                @(negedge clk);
            end
            check_value("result_o", result_o, exp_res);
            check_value("overflow_o", {31'd0, overflow_o}, {31'd0, exp_ovf});
            check_value("stall_o cycles", stall_cnt, exp_stall);
            @(posedge clk);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire alu_pkg::alu_req_t   req_i,
    input  wire                      flush_i,
    input  wire                      hilo_kill_i,
    output logic [alu_pkg::XLEN-1:0] result_o,
    output logic                     overflow_o,
    output logic                     stall_o
);

    alu_pkg::unit_req_t       mul_req;
    alu_pkg::unit_req_t       div_req;
    logic                     mul_ready;
    logic                     div_ready;
    alu_pkg::hilo_u           mul_result;
    alu_pkg::hilo_u           div_result;
    logic [alu_pkg::XLEN-1:0] logic_result;
    logic [alu_pkg::XLEN-1:0] hilo_result;
    logic                     use_hilo;

    alu_logic u_logic (
        .req_i      (req_i),
        .result_o   (logic_result),
        .overflow_o (overflow_o)
    );

    mul_unit u_mul (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .req_i    (mul_req),
        .ready_o  (mul_ready),
        .result_o (mul_result)
    );

    div_unit u_div (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .req_i    (div_req),
        .ready_o  (div_ready),
        .result_o (div_result)
    );

    hilo_ctrl u_hilo (
        .clk           (clk),
        .rst_i         (rst_i),
        .hilo_kill_i   (hilo_kill_i),
        .req_i         (req_i),
        .mul_ready_i   (mul_ready),
        .mul_result_i  (mul_result),
        .div_ready_i   (div_ready),
        .div_result_i  (div_result),
        .mul_req_o     (mul_req),
        .div_req_o     (div_req),
        .stall_o       (stall_o),
        .use_hilo_o    (use_hilo),
        .hilo_result_o (hilo_result)
    );

    // mfhi/mflo/mul results come from the hi/lo side
    assign result_o = use_hilo ? hilo_result : logic_result;

endmodule

`default_nettype wire

// File: verilog/hilo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_ctrl (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire                      hilo_kill_i,
    input  wire alu_pkg::alu_req_t   req_i,
    input  wire                      mul_ready_i,
    input  wire alu_pkg::hilo_u      mul_result_i,
    input  wire                      div_ready_i,
    input  wire alu_pkg::hilo_u      div_result_i,
    output alu_pkg::unit_req_t       mul_req_o,
    output alu_pkg::unit_req_t       div_req_o,
    output logic                     stall_o,
    output logic                     use_hilo_o,
    output logic [alu_pkg::XLEN-1:0] hilo_result_o
);

    logic           mul_op;
    logic           div_op;
    logic           op_signed;
    logic           hilo_we;
    alu_pkg::hilo_u hilo_q;
    alu_pkg::hilo_u hilo_d;

    // which unit the op needs, and signedness
    always_comb begin
        mul_op    = 1'b0;
        div_op    = 1'b0;
        op_signed = 1'b0;
        case (req_i.op)
            alu_pkg::OP_MULT, alu_pkg::OP_MUL, alu_pkg::OP_MADD, alu_pkg::OP_MSUB: begin
                mul_op    = 1'b1;
                op_signed = 1'b1;
            end
            alu_pkg::OP_MULTU, alu_pkg::OP_MADDU, alu_pkg::OP_MSUBU: mul_op = 1'b1;
            alu_pkg::OP_DIV: begin
                div_op    = 1'b1;
                op_signed = 1'b1;
            end
            alu_pkg::OP_DIVU: div_op = 1'b1;
            default: ;
        endcase
    end

    // start held until the unit answers with ready
    always_comb begin
        mul_req_o.start     = mul_op & ~mul_ready_i;
        mul_req_o.is_signed = op_signed;
        mul_req_o.opa       = req_i.src_a;
        mul_req_o.opb       = req_i.src_b;
        div_req_o.start     = div_op & ~div_ready_i;
        div_req_o.is_signed = op_signed;
        div_req_o.opa       = req_i.src_a;
        div_req_o.opb       = req_i.src_b;
    end

    assign stall_o = mul_req_o.start | div_req_o.start;

    always_comb begin
        hilo_d  = hilo_q;
        hilo_we = 1'b0;
        case (req_i.op)
            alu_pkg::OP_MULT, alu_pkg::OP_MULTU: begin
                hilo_d  = mul_result_i;
                hilo_we = mul_ready_i;
            end
            alu_pkg::OP_MADD, alu_pkg::OP_MADDU: begin
                hilo_d.raw = hilo_q.raw + mul_result_i.raw;
                hilo_we    = mul_ready_i;
            end
            alu_pkg::OP_MSUB, alu_pkg::OP_MSUBU: begin
                hilo_d.raw = hilo_q.raw - mul_result_i.raw;
                hilo_we    = mul_ready_i;
            end
            alu_pkg::OP_DIV, alu_pkg::OP_DIVU: begin
                hilo_d  = div_result_i;
                hilo_we = div_ready_i;
            end
            alu_pkg::OP_MTHI: begin
                hilo_d.parts.hi = req_i.src_a;
                hilo_we         = 1'b1;
            end
            alu_pkg::OP_MTLO: begin
                hilo_d.parts.lo = req_i.src_a;
                hilo_we         = 1'b1;
            end
            default: ;
        endcase
    end

    // a later-stage kill drops the write
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_q <= '0;
        end else if (hilo_we && !hilo_kill_i) begin
            hilo_q <= hilo_d;
        end
    end

    always_comb begin
        use_hilo_o = 1'b1;
        case (req_i.op)
            alu_pkg::OP_MFHI: hilo_result_o = hilo_q.parts.hi;
            alu_pkg::OP_MFLO: hilo_result_o = hilo_q.parts.lo;
            // MUL bypasses hi/lo, low word only
            alu_pkg::OP_MUL:  hilo_result_o = mul_ready_i ? mul_result_i.parts.lo : '0;
            default: begin
                use_hilo_o    = 1'b0;
                hilo_result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     flush_i,
    input  wire alu_pkg::unit_req_t req_i,
    output logic                    ready_o,
    output alu_pkg::hilo_u          result_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } state_t;

    state_t      state_q;
    logic [4:0]  step_q;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvsr_q;
    logic        rem_neg_q;
    logic        quo_neg_q;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [33:0] trial;

    assign mag_a = (req_i.is_signed && req_i.opa[31]) ? -req_i.opa : req_i.opa;
    assign mag_b = (req_i.is_signed && req_i.opb[31]) ? -req_i.opb : req_i.opb;

    // shift next dividend bit into the partial remainder and try the subtract
    assign trial = {1'b0, rem_q, quo_q[31]} - {2'b00, dvsr_q};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q <= S_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_i.start) begin
                        state_q <= S_BUSY;
                        step_q  <= '0;
                    end
                end
                S_BUSY: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd31) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // zero divisor never borrows: quotient all ones, remainder the dividend
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_i.start) begin
            rem_q     <= '0;
            quo_q     <= mag_a;
            dvsr_q    <= mag_b;
            rem_neg_q <= req_i.is_signed & req_i.opa[31];
            quo_neg_q <= req_i.is_signed & (req_i.opa[31] ^ req_i.opb[31]);
        end else if (state_q == S_BUSY) begin
            if (!trial[33]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                // restore, keep the shifted remainder
                rem_q <= {rem_q[30:0], quo_q[31]};
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    assign ready_o = (state_q == S_DONE);

    // remainder follows the dividend sign
    always_comb begin
        result_o.parts.hi = rem_neg_q ? -rem_q : rem_q;
        result_o.parts.lo = quo_neg_q ? -quo_q : quo_q;
    end

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     flush_i,
    input  wire alu_pkg::unit_req_t req_i,
    output logic                    ready_o,
    output alu_pkg::hilo_u          result_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } state_t;

    state_t      state_q;
    logic [4:0]  step_q;
    logic [63:0] prod_q;
    logic [31:0] mcand_q;
    logic        neg_q;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [32:0] part_sum;

    assign mag_a = (req_i.is_signed && req_i.opa[31]) ? -req_i.opa : req_i.opa;
    assign mag_b = (req_i.is_signed && req_i.opb[31]) ? -req_i.opb : req_i.opb;

    // multiplier sits in the low half, shifted out one bit per step
    assign part_sum = {1'b0, prod_q[63:32]} + (prod_q[0] ? {1'b0, mcand_q} : 33'd0);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q <= S_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_i.start) begin
                        state_q <= S_BUSY;
                        step_q  <= '0;
                    end
                end
                S_BUSY: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd31) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_i.start) begin
            prod_q  <= {32'd0, mag_b};
            mcand_q <= mag_a;
            neg_q   <= req_i.is_signed & (req_i.opa[31] ^ req_i.opb[31]);
        end else if (state_q == S_BUSY) begin
            prod_q <= {part_sum, prod_q[31:1]};
        end
    end

    assign ready_o      = (state_q == S_DONE);
    // sign fixup on the finished magnitude product
    assign result_o.raw = neg_q ? -prod_q : prod_q;

endmodule

`default_nettype wire

// File: verilog/alu_logic.sv
`timescale 1ns/1ps
`default_nettype none

module alu_logic (
    input  wire alu_pkg::alu_req_t  req_i,
    output logic [alu_pkg::XLEN-1:0] result_o,
    output logic                     overflow_o
);

    logic [alu_pkg::XLEN-1:0] a;
    logic [alu_pkg::XLEN-1:0] b;
    logic [alu_pkg::XLEN:0]   sum_ext;
    logic [alu_pkg::XLEN:0]   diff_ext;

    assign a = req_i.src_a;
    assign b = req_i.src_b;

    // one extra sign bit, the top two bits disagree on overflow
    assign sum_ext  = {a[31], a} + {b[31], b};
    assign diff_ext = {a[31], a} - {b[31], b};

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (req_i.op)
            alu_pkg::OP_NOP:  result_o = a;
            alu_pkg::OP_AND:  result_o = a & b;
            alu_pkg::OP_OR:   result_o = a | b;
            alu_pkg::OP_NOR:  result_o = ~(a | b);
            alu_pkg::OP_XOR:  result_o = a ^ b;

            alu_pkg::OP_ADD: begin
                result_o   = sum_ext[31:0];
                overflow_o = sum_ext[32] ^ sum_ext[31];
            end
            alu_pkg::OP_ADDU: result_o = sum_ext[31:0];
            alu_pkg::OP_SUB: begin
                result_o   = diff_ext[31:0];
                overflow_o = diff_ext[32] ^ diff_ext[31];
            end
            alu_pkg::OP_SUBU: result_o = diff_ext[31:0];

            alu_pkg::OP_SLT:  result_o = {31'd0, $signed(a) < $signed(b)};
            alu_pkg::OP_SLTU: result_o = {31'd0, a < b};

            // variable shifts take the amount from src_a
            alu_pkg::OP_SLLV: result_o = b << a[4:0];
            alu_pkg::OP_SRLV: result_o = b >> a[4:0];
            alu_pkg::OP_SRAV: result_o = $signed(b) >>> a[4:0];
            alu_pkg::OP_SLL:  result_o = b << req_i.sa;
            alu_pkg::OP_SRL:  result_o = b >> req_i.sa;
            alu_pkg::OP_SRA:  result_o = $signed(b) >>> req_i.sa;

            alu_pkg::OP_LUI:  result_o = {b[15:0], 16'd0};
            alu_pkg::OP_SEB:  result_o = {{24{b[7]}}, b[7:0]};
            alu_pkg::OP_SEH:  result_o = {{16{b[15]}}, b[15:0]};
            // swap bytes within each halfword
            alu_pkg::OP_WSBH: result_o = {b[23:16], b[31:24], b[7:0], b[15:8]};

            default: begin
                result_o   = '0;
                overflow_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int XLEN = 32;
    localparam int OP_W = 6;

    // single-cycle ops
    localparam logic [OP_W-1:0] OP_NOP   = 6'd0;
    localparam logic [OP_W-1:0] OP_AND   = 6'd1;
    localparam logic [OP_W-1:0] OP_OR    = 6'd2;
    localparam logic [OP_W-1:0] OP_NOR   = 6'd3;
    localparam logic [OP_W-1:0] OP_XOR   = 6'd4;
    localparam logic [OP_W-1:0] OP_ADD   = 6'd5;
    localparam logic [OP_W-1:0] OP_ADDU  = 6'd6;
    localparam logic [OP_W-1:0] OP_SUB   = 6'd7;
    localparam logic [OP_W-1:0] OP_SUBU  = 6'd8;
    localparam logic [OP_W-1:0] OP_SLT   = 6'd9;
    localparam logic [OP_W-1:0] OP_SLTU  = 6'd10;
    localparam logic [OP_W-1:0] OP_SLLV  = 6'd11;
    localparam logic [OP_W-1:0] OP_SRLV  = 6'd12;
    localparam logic [OP_W-1:0] OP_SRAV  = 6'd13;
    localparam logic [OP_W-1:0] OP_SLL   = 6'd14;
    localparam logic [OP_W-1:0] OP_SRL   = 6'd15;
    localparam logic [OP_W-1:0] OP_SRA   = 6'd16;
    localparam logic [OP_W-1:0] OP_LUI   = 6'd17;
    localparam logic [OP_W-1:0] OP_SEB   = 6'd18;
    localparam logic [OP_W-1:0] OP_SEH   = 6'd19;
    localparam logic [OP_W-1:0] OP_WSBH  = 6'd20;
    // multiply / divide class
    localparam logic [OP_W-1:0] OP_MULT  = 6'd21;
    localparam logic [OP_W-1:0] OP_MULTU = 6'd22;
    localparam logic [OP_W-1:0] OP_DIV   = 6'd23;
    localparam logic [OP_W-1:0] OP_DIVU  = 6'd24;
    localparam logic [OP_W-1:0] OP_MUL   = 6'd25;
    localparam logic [OP_W-1:0] OP_MADD  = 6'd26;
    localparam logic [OP_W-1:0] OP_MADDU = 6'd27;
    localparam logic [OP_W-1:0] OP_MSUB  = 6'd28;
    localparam logic [OP_W-1:0] OP_MSUBU = 6'd29;
    // hi/lo moves
    localparam logic [OP_W-1:0] OP_MTHI  = 6'd30;
    localparam logic [OP_W-1:0] OP_MTLO  = 6'd31;
    localparam logic [OP_W-1:0] OP_MFHI  = 6'd32;
    localparam logic [OP_W-1:0] OP_MFLO  = 6'd33;

    typedef struct packed {
        logic [OP_W-1:0] op;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        logic [4:0]      sa;
    } alu_req_t;

    // full 64-bit product, or the hi and lo words seen separately
    typedef union packed {
        logic [2*XLEN-1:0] raw;
        struct packed {
            logic [XLEN-1:0] hi;
            logic [XLEN-1:0] lo;
        } parts;
    } hilo_u;

    typedef struct packed {
        logic            start;
        logic            is_signed;
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
    } unit_req_t;

endpackage

`default_nettype wire
